/* bench/conv1x1_sva.sv */
`timescale 1ns/100ps

// Pacing rules on the inputs and the output protocol
module conv1x1_sva (
  input logic clk,
  input logic reset,
  input logic weight_strobe,
  input logic pixel_strobe,
  input logic busy,
  input logic out_pulse,
  input logic out_cause
);

  // The replay reads the weight store
  weight_during_replay: assert property (
    @(posedge clk) disable iff (reset) weight_strobe |-> !busy
  ) else $error("Weight strobe while a replay is running");

  // Only one pixel can be replayed at a time
  pixel_during_replay: assert property (
    @(posedge clk) disable iff (reset) pixel_strobe |-> !busy
  ) else $error("Pixel completed while a replay is running");

  // Memory read, product and accumulate stages sit between last and valid_out
  out_without_last: assert property (
    @(posedge clk) disable iff (reset) out_pulse |-> $past(out_cause, 3)
  ) else $error("valid_out without a preceding last");

endmodule

//////////////////////////////////////////////////
// Attach to the controller and the MAC
//////////////////////////////////////////////////

bind conv_ctrl conv1x1_sva i_ctrl_sva (
  .clk           (clk            ),
  .reset         (reset          ),
  .weight_strobe (valid_weight_in),
  .pixel_strobe  (pixel_done     ),
  .busy          (busy           ),
  .out_pulse     (1'b0           ),
  .out_cause     (1'b0           )
);

bind conv_mac conv1x1_sva i_mac_sva (
  .clk           (clk            ),
  .reset         (reset          ),
  .weight_strobe (1'b0           ),
  .pixel_strobe  (1'b0           ),
  .busy          (1'b0           ),
  .out_pulse     (valid_out      ),
  .out_cause     (seq.last       )
);

/* bench/conv1x1_tb.sv */
`timescale 1ns/100ps
`include "conv1x1_consts.svh"

module conv1x1_tb;

  localparam int WGT_COUNT = `CONV_CH_OUT * `CONV_CH_IN;
  localparam int REPLAY    = WGT_COUNT;
  // Last output channel leaves this many edges after the pixel completes
  localparam int DRAIN     = REPLAY + 2;
  localparam int PXL_MAX   = (1 << (`CONV_DATA_WIDTH - 1)) - 1;
  localparam int PXL_MIN   = -PXL_MAX - 1;

  localparam int N_RANDOM  = 24;
  localparam int N_SAT     = 12;
  localparam int N_OVERLAP = 12;
  localparam int N_RELOAD  = 16;
  localparam int N_PIXELS  = N_RANDOM + N_SAT + N_OVERLAP + N_RELOAD;
  // Channel writes, one replay, idle gap and drain per pixel
  localparam int PIXEL_CYCLES = `CONV_CH_IN + REPLAY + 4 + DRAIN;
  localparam int TEST_CYCLES  = N_PIXELS * PIXEL_CYCLES + 4 * (WGT_COUNT + REPLAY) + 40;

  logic                 clk = 1'b0;
  logic                 reset;
  logic                 valid_in;
  logic                 valid_weight_in;
  conv1x1_pkg::pixel_t  pxl_in;
  conv1x1_pkg::weight_t weight_in;
  conv1x1_pkg::pixel_t  pxl_out;
  logic                 valid_out;

  integer seed = 32'h19d5;
  int     cyc = 0;
  // Edge that sampled the last completed pixel, far in the past at start
  int     last_edge = -100;
  int     out_count = 0;
  int     count_start;
  string  test_name = "reset";

  conv1x1_pkg::weight_t wgt_model [WGT_COUNT];
  conv1x1_pkg::pixel_t  pix_cur [`CONV_CH_IN];
  conv1x1_pkg::pixel_t  exp_q [$];

  conv1x1_layer i_conv1x1_layer (
    .clk             (clk            ),
    .reset           (reset          ),
    .valid_in        (valid_in       ),
    .valid_weight_in (valid_weight_in),
    .pxl_in          (pxl_in         ),
    .weight_in       (weight_in      ),
    .pxl_out         (pxl_out        ),
    .valid_out       (valid_out      )
  );

  always #5 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_pixel(input string name, input conv1x1_pkg::pixel_t expected,
                             input conv1x1_pkg::pixel_t actual);
    if (actual !== expected) begin
      report_failure($sformatf("Mismatch in %s: expected %0d, actual %0d",
                               name, expected, actual));
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      report_failure($sformatf("Mismatch in %s: expected %b, actual %b",
                               name, expected, actual));
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    if (actual < expected) begin
      report_failure($sformatf("Test %s is missing %0d outputs", name, expected - actual));
    end else if (actual > expected) begin
      report_failure($sformatf("Test %s produced %0d extra outputs", name, actual - expected));
    end
  endtask

  // Outputs are compared in output-channel order
  always @(negedge clk) begin
    if (!reset && valid_out) begin
      if (exp_q.size() == 0) begin
        report_failure({"Output appeared with no pixel pending in test ", test_name});
      end else begin
        check_pixel(test_name, exp_q.pop_front(), pxl_out);
        out_count++;
      end
    end
  end

  initial begin
    repeat (2 * TEST_CYCLES) @(posedge clk);
    report_failure($sformatf("Timeout, tests did not finish within %0d cycles",
                             2 * TEST_CYCLES));
  end

  //////////////////////////////////////////////////
  // Stimulus and reference model
  //////////////////////////////////////////////////

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  function automatic int rand_range(input int lo, input int hi);
    int r;
    r = $random(seed);
    r = r & 32'h7fff_ffff;
    return lo + r % (hi - lo + 1);
  endfunction

  // Floor-shifted products, summed and clamped to the pixel range
  function automatic conv1x1_pkg::pixel_t expected_channel(input int co);
    longint sum;
    longint prod;
    sum = 0;
    for (int ci = 0; ci < `CONV_CH_IN; ci++) begin
      prod = longint'(wgt_model[co * `CONV_CH_IN + ci]) * longint'(pix_cur[ci]);
      sum += prod >>> `CONV_FRAC_BITS;
    end
    if (sum > PXL_MAX) sum = PXL_MAX;
    if (sum < PXL_MIN) sum = PXL_MIN;
    return conv1x1_pkg::pixel_t'(sum);
  endfunction

  // Next completion or weight strobe must not land inside a replay
  task automatic wait_replay_done();
    valid_in        = 1'b0;
    valid_weight_in = 1'b0;
    while (cyc < last_edge + REPLAY) tick();
  endtask

  task automatic load_weights(input int lo, input int hi, input bit split_sign);
    int w;
    wait_replay_done();
    for (int i = 0; i < WGT_COUNT; i++) begin
      w = rand_range(lo, hi);
      // Upper output channels get negative weights
      if (split_sign && (i / `CONV_CH_IN) >= `CONV_CH_OUT / 2) w = -w;
      wgt_model[i]    = conv1x1_pkg::weight_t'(w);
      valid_weight_in = 1'b1;
      weight_in       = wgt_model[i];
      tick();
    end
    valid_weight_in = 1'b0;
  endtask

  task automatic fill_pixel(input int lo, input int hi, input bit negate);
    int v;
    for (int ci = 0; ci < `CONV_CH_IN; ci++) begin
      v = rand_range(lo, hi);
      pix_cur[ci] = conv1x1_pkg::pixel_t'(negate ? -v : v);
    end
  endtask

  task automatic drive_pixel();
    for (int ci = 0; ci < `CONV_CH_IN; ci++) begin
      if (ci == `CONV_CH_IN - 1) wait_replay_done();
      valid_in = 1'b1;
      pxl_in   = pix_cur[ci];
      if (ci == `CONV_CH_IN - 1) begin
        last_edge = cyc + 1;
        for (int co = 0; co < `CONV_CH_OUT; co++) exp_q.push_back(expected_channel(co));
      end
      tick();
    end
    valid_in = 1'b0;
  endtask

  task automatic begin_test(input string name);
    test_name   = name;
    count_start = out_count;
  endtask

  task automatic end_test(input int pixels);
    while (cyc < last_edge + DRAIN + 1) tick();
    check_count(test_name, pixels * `CONV_CH_OUT, out_count - count_start);
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    reset           = 1'b1;
    valid_in        = 1'b0;
    valid_weight_in = 1'b0;
    pxl_in          = '0;
    weight_in       = '0;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;

    // Quiet output after reset
    repeat (8) begin
      check_flag("reset", 1'b0, valid_out);
      tick();
    end

    begin_test("random");
    load_weights(-512, 512, 1'b0);
    for (int p = 0; p < N_RANDOM; p++) begin
      fill_pixel(-1024, 1024, 1'b0);
      drive_pixel();
      wait_replay_done();
      repeat (rand_range(0, 3)) tick();
    end
    end_test(N_RANDOM);

    begin_test("saturation");
    load_weights(16384, PXL_MAX, 1'b1);
    for (int p = 0; p < N_SAT; p++) begin
      fill_pixel(16384, PXL_MAX, rand_range(0, 1) == 1);
      drive_pixel();
    end
    end_test(N_SAT);

    // Three channels of each pixel arrive during the previous replay
    begin_test("overlap");
    load_weights(-512, 512, 1'b0);
    for (int p = 0; p < N_OVERLAP; p++) begin
      fill_pixel(-1024, 1024, 1'b0);
      drive_pixel();
    end
    end_test(N_OVERLAP);

    begin_test("reload");
    for (int b = 0; b < 2; b++) begin
      load_weights(-768, 768, 1'b0);
      for (int p = 0; p < N_RELOAD / 2; p++) begin
        fill_pixel(-1024, 1024, 1'b0);
        drive_pixel();
      end
    end
    end_test(N_RELOAD);

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the conv1x1 testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_EXE=conv1x1_sim
LOG_FILE=sim.log

verilator --binary --timing --assert \
  -f sources.f \
  --top-module conv1x1_tb \
  -Mdir "$BUILD_DIR" \
  -o "$SIM_EXE"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$SIM_EXE" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "Simulation failed" "$LOG_FILE"; then
  exit 1
fi
exit 0

/* sources.f */
+incdir+verilog
verilog/conv1x1_pkg.sv
verilog/conv_seq_if.sv
verilog/conv_mem.sv
verilog/conv_ctrl.sv
verilog/conv_mac.sv
verilog/conv1x1_layer.sv
bench/conv1x1_sva.sv
bench/conv1x1_tb.sv

/* verilog/conv1x1_consts.svh */
`ifndef CONV1X1_CONSTS_SVH
`define CONV1X1_CONSTS_SVH

//////////////////////////////////////////////////
// Number format
//////////////////////////////////////////////////

// Pixels, weights and results are signed Q8.8
`define CONV_DATA_WIDTH 16
`define CONV_FRAC_BITS  8

// Wide enough for CONV_CH_IN shifted products
`define CONV_ACC_WIDTH  32

//////////////////////////////////////////////////
// Layer shape
//////////////////////////////////////////////////

`define CONV_CH_IN      4
`define CONV_CH_OUT     4

`endif

/* verilog/conv1x1_layer.sv */
`timescale 1ns/100ps
`include "conv1x1_consts.svh"

module conv1x1_layer (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 valid_in,
  input  logic                 valid_weight_in,
  input  conv1x1_pkg::pixel_t  pxl_in,
  input  conv1x1_pkg::weight_t weight_in,
  output conv1x1_pkg::pixel_t  pxl_out,
  output logic                 valid_out
);

  localparam int PXL_DEPTH = 2 * `CONV_CH_IN;
  localparam int WGT_DEPTH = `CONV_CH_OUT * `CONV_CH_IN;

  // Write side from the controller
  logic                   pxl_wr_en;
  conv1x1_pkg::pxl_addr_t pxl_wr_addr;
  conv1x1_pkg::wgt_addr_t wgt_wr_addr;

  // Memory read data into the MAC
  conv1x1_pkg::pixel_t    pxl_rd_data;
  conv1x1_pkg::weight_t   wgt_rd_data;

  conv_seq_if seq ();

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////

  // busy is only observed by the bound checker
  conv_ctrl i_ctrl (
    .clk             (clk            ),
    .reset           (reset          ),
    .valid_in        (valid_in       ),
    .valid_weight_in (valid_weight_in),
    .pxl_wr_en       (pxl_wr_en      ),
    .pxl_wr_addr     (pxl_wr_addr    ),
    .wgt_wr_addr     (wgt_wr_addr    ),
    .busy            (               ),
    .seq             (seq.ctrl       )
  );

  //////////////////////////////////////////////////
  // Pixel ping-pong buffer and weight store
  //////////////////////////////////////////////////

  conv_mem #(
    .entry_t (conv1x1_pkg::pixel_t),
    .DEPTH   (PXL_DEPTH           )
  ) i_pxl_mem (
    .clk     (clk         ),
    .wr_en   (pxl_wr_en   ),
    .wr_addr (pxl_wr_addr ),
    .wr_data (pxl_in      ),
    .rd_addr (seq.pxl_addr),
    .rd_data (pxl_rd_data )
  );

  conv_mem #(
    .entry_t (conv1x1_pkg::weight_t),
    .DEPTH   (WGT_DEPTH            )
  ) i_wgt_mem (
    .clk     (clk            ),
    .wr_en   (valid_weight_in),
    .wr_addr (wgt_wr_addr    ),
    .wr_data (weight_in      ),
    .rd_addr (seq.wgt_addr   ),
    .rd_data (wgt_rd_data    )
  );

  //////////////////////////////////////////////////
  // Multiply-accumulate
  //////////////////////////////////////////////////

  conv_mac i_mac (
    .clk       (clk        ),
    .reset     (reset      ),
    .seq       (seq.mac    ),
    .pxl_data  (pxl_rd_data),
    .wgt_data  (wgt_rd_data),
    .pxl_out   (pxl_out    ),
    .valid_out (valid_out  )
  );

endmodule

/* verilog/conv1x1_pkg.sv */
`include "conv1x1_consts.svh"

package conv1x1_pkg;

  // Data words
  typedef logic signed [`CONV_DATA_WIDTH-1:0] pixel_t;
  typedef logic signed [`CONV_DATA_WIDTH-1:0] weight_t;

  // Running sum of the shifted products
  typedef logic signed [`CONV_ACC_WIDTH-1:0] acc_t;

  //////////////////////////////////////////////////
  // Memory addresses
  //////////////////////////////////////////////////

  // Two banks of CONV_CH_IN pixels, bank bit on top
  typedef logic [$clog2(2*`CONV_CH_IN)-1:0] pxl_addr_t;

  // Weights ordered by output channel, then input channel
  typedef logic [$clog2(`CONV_CH_OUT*`CONV_CH_IN)-1:0] wgt_addr_t;

endpackage

/* verilog/conv_ctrl.sv */
`timescale 1ns/100ps
`include "conv1x1_consts.svh"

module conv_ctrl (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   valid_in,
  input  logic                   valid_weight_in,
  output logic                   pxl_wr_en,
  output conv1x1_pkg::pxl_addr_t pxl_wr_addr,
  output conv1x1_pkg::wgt_addr_t wgt_wr_addr,
  output logic                   busy,
  conv_seq_if.ctrl               seq
);

  localparam int CH_IN_W  = $clog2(`CONV_CH_IN);
  localparam int CH_OUT_W = $clog2(`CONV_CH_OUT);
  localparam int WGT_LAST = `CONV_CH_OUT * `CONV_CH_IN - 1;

  // Pixel write side
  logic [CH_IN_W-1:0]  wr_ch;
  logic                wr_bank;
  logic                pixel_done;

  // Replay side
  logic                rd_bank;
  logic [CH_OUT_W-1:0] rd_out;
  logic [CH_IN_W-1:0]  rd_in;
  logic                rd_in_last;
  logic                rd_out_last;

  //////////////////////////////////////////////////
  // Weight write counter
  //////////////////////////////////////////////////

  // Wraps so that a full reload starts again at entry 0
  always_ff @(posedge clk) begin
    if (reset) begin
      wgt_wr_addr <= '0;
    end else if (valid_weight_in) begin
      if (wgt_wr_addr == conv1x1_pkg::wgt_addr_t'(WGT_LAST)) begin
        wgt_wr_addr <= '0;
      end else begin
        wgt_wr_addr <= wgt_wr_addr + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Pixel write counter and bank
  //////////////////////////////////////////////////

  assign pixel_done = valid_in && (wr_ch == CH_IN_W'(`CONV_CH_IN - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ch   <= '0;
      wr_bank <= 1'b0;
    end else if (valid_in) begin
      if (pixel_done) begin
        // Next pixel goes to the other bank
        wr_ch   <= '0;
        wr_bank <= ~wr_bank;
      end else begin
        wr_ch <= wr_ch + 1'b1;
      end
    end
  end

  assign pxl_wr_en   = valid_in;
  assign pxl_wr_addr = {wr_bank, wr_ch};

  //////////////////////////////////////////////////
  // Replay sequencer
  //////////////////////////////////////////////////

  assign rd_in_last  = (rd_in == CH_IN_W'(`CONV_CH_IN - 1));
  assign rd_out_last = (rd_out == CH_OUT_W'(`CONV_CH_OUT - 1));

  // Input channel is the inner loop, output channel the outer one
  always_ff @(posedge clk) begin
    if (reset) begin
      busy    <= 1'b0;
      rd_bank <= 1'b0;
      rd_out  <= '0;
      rd_in   <= '0;
    end else if (pixel_done) begin
      // Replay the bank that was just completed
      busy    <= 1'b1;
      rd_bank <= wr_bank;
      rd_out  <= '0;
      rd_in   <= '0;
    end else if (busy) begin
      if (rd_in_last) begin
        rd_in <= '0;
        if (rd_out_last) begin
          busy   <= 1'b0;
          rd_out <= '0;
        end else begin
          rd_out <= rd_out + 1'b1;
        end
      end else begin
        rd_in <= rd_in + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Sequence outputs
  //////////////////////////////////////////////////

  assign seq.rd_en    = busy;
  assign seq.pxl_addr = {rd_bank, rd_in};
  assign seq.wgt_addr = conv1x1_pkg::wgt_addr_t'(rd_out * `CONV_CH_IN + rd_in);

  // Frame each output channel's accumulation
  assign seq.first    = busy && (rd_in == '0);
  assign seq.last     = busy && rd_in_last;

endmodule

/* verilog/conv_mac.sv */
`timescale 1ns/100ps
`include "conv1x1_consts.svh"

module conv_mac (
  input  logic                clk,
  input  logic                reset,
  conv_seq_if.mac             seq,
  input  conv1x1_pkg::pixel_t  pxl_data,
  input  conv1x1_pkg::weight_t wgt_data,
  output conv1x1_pkg::pixel_t  pxl_out,
  output logic                valid_out
);

  localparam conv1x1_pkg::acc_t PXL_MAX =
    conv1x1_pkg::acc_t'({1'b0, {(`CONV_DATA_WIDTH-1){1'b1}}});
  localparam conv1x1_pkg::acc_t PXL_MIN = -PXL_MAX - 1;

  // Sequence flags lined up with the memory data
  logic              vld_d, first_d, last_d;
  // Same flags lined up with the product register
  logic              vld_p, first_p, last_p;

  conv1x1_pkg::acc_t prod_full;
  conv1x1_pkg::acc_t prod_q;
  conv1x1_pkg::acc_t acc_q;
  conv1x1_pkg::acc_t acc_next;
  conv1x1_pkg::pixel_t sat_val;

  //////////////////////////////////////////////////
  // Flag delays
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      vld_d   <= 1'b0;
      first_d <= 1'b0;
      last_d  <= 1'b0;
      vld_p   <= 1'b0;
      first_p <= 1'b0;
      last_p  <= 1'b0;
    end else begin
      vld_d   <= seq.rd_en;
      first_d <= seq.first;
      last_d  <= seq.last;
      vld_p   <= vld_d;
      first_p <= first_d;
      last_p  <= last_d;
    end
  end

  //////////////////////////////////////////////////
  // Multiply and accumulate
  //////////////////////////////////////////////////

  // Q8.8 times Q8.8, floor back to Q8.8
  assign prod_full = conv1x1_pkg::acc_t'(wgt_data) * conv1x1_pkg::acc_t'(pxl_data);

  always_ff @(posedge clk) begin
    prod_q <= prod_full >>> `CONV_FRAC_BITS;
  end

  assign acc_next = first_p ? prod_q : acc_q + prod_q;

  always_ff @(posedge clk) begin
    if (vld_p) begin
      acc_q <= acc_next;
    end
  end

  //////////////////////////////////////////////////
  // Saturate and register output
  //////////////////////////////////////////////////

  always_comb begin
    if (acc_next > PXL_MAX) begin
      sat_val = conv1x1_pkg::pixel_t'(PXL_MAX);
    end else if (acc_next < PXL_MIN) begin
      sat_val = conv1x1_pkg::pixel_t'(PXL_MIN);
    end else begin
      sat_val = conv1x1_pkg::pixel_t'(acc_next);
    end
  end

  always_ff @(posedge clk) begin
    if (vld_p && last_p) begin
      pxl_out <= sat_val;
    end
  end

  // One pulse per output channel
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_out <= 1'b0;
    end else begin
      valid_out <= vld_p && last_p;
    end
  end

endmodule

/* verilog/conv_mem.sv */
`timescale 1ns/100ps

// Register file, synchronous write, registered read
module conv_mem #(
  parameter type entry_t = logic [15:0],
  parameter int  DEPTH   = 8
) (
  input  logic                     clk,
  input  logic                     wr_en,
  input  logic [$clog2(DEPTH)-1:0] wr_addr,
  input  entry_t                   wr_data,
  input  logic [$clog2(DEPTH)-1:0] rd_addr,
  output entry_t                   rd_data
);

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  entry_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  //////////////////////////////////////////////////
  // Read port
  //////////////////////////////////////////////////

  // Data valid one cycle after the address is sampled
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

/* verilog/conv_seq_if.sv */
`timescale 1ns/100ps

// Replay sequence from the controller towards the memories and the MAC
interface conv_seq_if;

  // One read per cycle while a replay runs
  logic                   rd_en;
  conv1x1_pkg::pxl_addr_t pxl_addr;
  conv1x1_pkg::wgt_addr_t wgt_addr;

  // Accumulation boundaries
  logic                   first;
  logic                   last;

  modport ctrl (
    output rd_en,
    output pxl_addr,
    output wgt_addr,
    output first,
    output last
  );

  // Addresses go straight to the memories at the top level
  modport mac (
    input rd_en,
    input first,
    input last
  );

endinterface
